// ==== sources.f ====
sat_bin_pkg.sv
bin_store.sv
load_bin.sv
clause_slot.sv
bin_eval.sv
sat_bin_top.sv
bin_checker.sv
tb_sat_bin.sv

// ==== Makefile ====
# Verilator build and run for the bin-swap testbench

VERILATOR ?= verilator
TB_TOP    ?= tb_sat_bin
RTL_TOP   ?= sat_bin_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "all tests passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) sat_bin_pkg.sv bin_store.sv \
		load_bin.sv clause_slot.sv bin_eval.sv sat_bin_top.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bin_trace.txt ====
# M sel start count data...  (sel 0 clause, 1 var id, 2 var state, 3 level entry)
# R bin cur_lvl base sat conflict units open dup   (all hex)
M 0 008 8 0001 0008 0010 0080 1000 8000 0101 0009
M 0 010 8 0002 0001 0100 0001 0001 0001 0001 0001
M 0 018 8 0100 0400 0500 0102 0001 0001 0001 0001
M 1 008 8 010 011 012 013 014 015 016 017
M 1 010 8 010 011 012 013 014 015 016 017
M 1 018 8 010 011 012 013 014 015 016 017
M 2 010 8 601 401 602 402 000 000 603 403
M 3 010 5 002 003 002 002 003
M 3 000 4 006 006 007 006
R 001 014 010 1 0 0 0 0
R 002 030 030 0 1 1 1 0
R 003 003 000 0 0 3 4 0
R 001 012 010 1 0 0 0 1

// ==== tb_sat_bin.sv ====
`timescale 1ns/1ps
`default_nettype none
// testbench with clock, reset, level list fill and trace-driven loads

module tb_sat_bin;
    import sat_bin_pkg::*;

    localparam int TIMEOUT = 2000;

    logic                      clk;
    logic                      rst;
    host_wr_t                  host_wr;
    logic                      start_load;
    logic [WIDTH_BIN_ID-1:0]   request_bin;
    logic [WIDTH_LVL-1:0]      cur_lvl;
    logic                      load_busy;
    logic                      done_load;
    logic [WIDTH_LVL-1:0]      base_lvl;
    logic                      base_lvl_valid;
    lvl_state_t                lvl_state;
    logic [NUM_LVLS_A_BIN-1:0] wr_lvl_states;
    logic                      status_valid;
    bin_status_t               bin_status;
    int                        num_pass;
    int                        num_fail;

    // shadow of the level list for expected level streams
    logic [10:0] lvl_shadow [LVL_DEPTH];
    bit          aborted;
    int          req_no;

    sat_bin_top u_sat_bin_top (
        .clk              (clk),
        .rst              (rst),
        .host_wr_i        (host_wr),
        .start_load_i     (start_load),
        .request_bin_i    (request_bin),
        .cur_lvl_i        (cur_lvl),
        .load_busy_o      (load_busy),
        .done_load_o      (done_load),
        .base_lvl_o       (base_lvl),
        .base_lvl_valid_o (base_lvl_valid),
        .lvl_state_o      (lvl_state),
        .wr_lvl_states_o  (wr_lvl_states),
        .status_valid_o   (status_valid),
        .bin_status_o     (bin_status)
    );

    bin_checker u_checker (
        .clk              (clk),
        .rst              (rst),
        .load_busy_i      (load_busy),
        .done_load_i      (done_load),
        .base_lvl_i       (base_lvl),
        .base_lvl_valid_i (base_lvl_valid),
        .lvl_state_i      (lvl_state),
        .wr_lvl_states_i  (wr_lvl_states),
        .wr_carray_i      (u_sat_bin_top.wr_carray),
        .wr_var_states_i  (u_sat_bin_top.wr_var_states),
        .status_valid_i   (status_valid),
        .bin_status_i     (bin_status),
        .num_pass_o       (num_pass),
        .num_fail_o       (num_fail)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic host_write(input logic [1:0] sel, input logic [8:0] addr,
                              input logic [15:0] data);
        host_wr.strobe = 1'b1;
        host_wr.sel    = sel;
        host_wr.addr   = addr;
        host_wr.data   = data;
        if (sel == MEM_LSTATE)
            lvl_shadow[addr] = data[10:0];
        tick();
        host_wr.strobe = 1'b0;
    endtask

    // fill bin ids start at 0x200 and are never requested
    task automatic fill_level_list();
        for (int a = 0; a < LVL_DEPTH; a++)
            host_write(MEM_LSTATE, 9'(a), 16'({1'b1, 9'(a), a[0]}));
    endtask

    task automatic wait_high(input string name, ref logic sig);
        int cnt;
        cnt = 0;
        while (!sig && cnt < TIMEOUT)
        begin
            tick();
            cnt++;
        end
        if (!sig)
        begin
            $display("timeout waiting for %s to go high", name);
            aborted = 1'b1;
        end
    endtask

    task automatic run_request(input logic [9:0] bin, input logic [8:0] lvl,
                               input logic [8:0] base, input logic sat, input logic conf,
                               input logic [3:0] units, input logic [3:0] open,
                               input logic dup);
        logic [8:0] a;
        for (int i = 0; i < NUM_LVLS_A_BIN; i++)
        begin
            a = base + 9'(i);
            u_checker.expect_lvl(i, lvl_shadow[a]);
        end
        u_checker.expect_load(base, sat, conf, units, open);
        request_bin = bin;
        cur_lvl     = lvl;
        start_load  = 1'b1;
        tick();
        start_load  = 1'b0;
        if (dup)
        begin
            wait_high("load_busy_o", load_busy);
            // another bin makes an accepted restart visible
            request_bin = bin + 1'b1;
            start_load  = 1'b1;
            tick();
            start_load  = 1'b0;
        end
        if (!aborted)
            wait_high("done_load_o", done_load);
        if (!aborted)
            wait_high("status_valid_o", status_valid);
        if (!aborted)
        begin
            // watch for stray done or status pulses
            for (int i = 0; i < 12; i++)
                tick();
            u_checker.end_test($sformatf("request %0d bin %0h", req_no, bin), 1'b1);
        end
    endtask

    initial
    begin
        int         fd;
        int         code;
        logic [7:0] rec;
        logic [8*200-1:0] line;
        logic [15:0] f [8];

        host_wr     = '0;
        start_load  = 1'b0;
        request_bin = '0;
        cur_lvl     = '0;
        rst         = 1'b0;
        aborted     = 1'b0;
        req_no      = 0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b1;
        tick();
        u_checker.check_reset_state();
        u_checker.end_test("reset", 1'b0);
        fill_level_list();

        fd = $fopen("bin_trace.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the trace file");
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd))
        begin
            code = $fscanf(fd, " %c", rec);
            if (code != 1)
                break;
            if (rec == "#")
                code = $fgets(line, fd);
            else if (rec == "M")
            begin
                code = $fscanf(fd, " %h %h %h", f[0], f[1], f[2]);
                for (int i = 0; i < int'(f[2]); i++)
                begin
                    code = $fscanf(fd, " %h", f[3]);
                    host_write(f[0][1:0], f[1][8:0] + 9'(i), f[3]);
                end
            end
            else if (rec == "R")
            begin
                code = $fscanf(fd, " %h %h %h %h %h %h %h %h",
                               f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                req_no++;
                run_request(f[0][9:0], f[1][8:0], f[2][8:0], f[3][0], f[4][0],
                            f[5][3:0], f[6][3:0], f[7][0]);
            end
            else
            begin
                $display("unknown trace record type %c", rec);
                aborted = 1'b1;
            end
        end
        if (fd != 0)
            $fclose(fd);

        $display("tests run %0d, passed %0d, failed %0d",
                 num_pass + num_fail, num_pass, num_fail);
        if (aborted || num_fail != 0 || req_no == 0)
            $display("tests failed");
        else
            $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bin_checker.sv ====
`timescale 1ns/1ps
`default_nettype none
// watches loader strobes, base level and bin status against expected values

module bin_checker
    import sat_bin_pkg::*;
(
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          load_busy_i,
    input  wire                          done_load_i,
    input  wire [WIDTH_LVL-1:0]          base_lvl_i,
    input  wire                          base_lvl_valid_i,
    input  wire lvl_state_t              lvl_state_i,
    input  wire [NUM_LVLS_A_BIN-1:0]     wr_lvl_states_i,
    input  wire [NUM_CLAUSES_A_BIN-1:0]  wr_carray_i,
    input  wire [NUM_VARS_A_BIN-1:0]     wr_var_states_i,
    input  wire                          status_valid_i,
    input  wire bin_status_t             bin_status_i,
    output int                           num_pass_o,
    output int                           num_fail_o
);

    logic [10:0]          exp_lvl [NUM_LVLS_A_BIN];
    logic [WIDTH_LVL-1:0] exp_base;
    bin_status_t          exp_status;
    int errors;
    int done_cnt;
    int status_cnt;
    int c_pos;
    int v_pos;
    int l_pos;

    initial
    begin
        num_pass_o = 0;
        num_fail_o = 0;
        errors     = 0;
        done_cnt   = 0;
        status_cnt = 0;
        c_pos      = 0;
        v_pos      = 0;
        l_pos      = 0;
    end

    task automatic mismatch(input string name, input logic [15:0] exp, input logic [15:0] got);
        $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
        errors++;
    endtask

    task automatic fault(input string msg);
        $display("error at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic expect_lvl(input int idx, input logic [10:0] val);
        exp_lvl[idx] = val;
    endtask

    task automatic expect_load(input logic [WIDTH_LVL-1:0] base, input logic sat,
                               input logic conf, input logic [3:0] units,
                               input logic [3:0] open);
        exp_base                = base;
        exp_status.bin_sat      = sat;
        exp_status.bin_conflict = conf;
        exp_status.unit_cnt     = units;
        exp_status.open_cnt     = open;
    endtask

    // one bit per cycle from bit 0 up with no gaps
    task automatic step_stream(input string name, input logic [7:0] stb, inout int pos);
        if (stb != '0)
        begin
            if (pos >= 8 || stb != 8'(1 << pos))
                mismatch(name, 16'(1 << pos), 16'(stb));
            pos++;
        end
        else if (pos > 0 && pos < 8)
        begin
            fault({name, " strobe stream has a gap"});
            pos = 100;
        end
    endtask

    always @(posedge clk)
    begin
        if (rst)
        begin
            if (wr_lvl_states_i != '0 && l_pos < 8 && wr_lvl_states_i == 8'(1 << l_pos))
            begin
                if (lvl_state_i !== exp_lvl[l_pos])
                    mismatch("lvl_state_o", 16'(exp_lvl[l_pos]), 16'(lvl_state_i));
            end
            step_stream("wr_carray", wr_carray_i, c_pos);
            step_stream("wr_var_states", wr_var_states_i, v_pos);
            step_stream("wr_lvl_states_o", wr_lvl_states_i, l_pos);
            if (done_load_i)
            begin
                done_cnt++;
                if (!base_lvl_valid_i)
                    fault("base_lvl_valid_o low at done_load_o");
                if (base_lvl_i !== exp_base)
                    mismatch("base_lvl_o", 16'(exp_base), 16'(base_lvl_i));
            end
            if (status_valid_i)
            begin
                status_cnt++;
                if (bin_status_i.bin_sat !== exp_status.bin_sat)
                    mismatch("bin_sat", 16'(exp_status.bin_sat), 16'(bin_status_i.bin_sat));
                if (bin_status_i.bin_conflict !== exp_status.bin_conflict)
                    mismatch("bin_conflict", 16'(exp_status.bin_conflict),
                             16'(bin_status_i.bin_conflict));
                if (bin_status_i.unit_cnt !== exp_status.unit_cnt)
                    mismatch("unit_cnt", 16'(exp_status.unit_cnt), 16'(bin_status_i.unit_cnt));
                if (bin_status_i.open_cnt !== exp_status.open_cnt)
                    mismatch("open_cnt", 16'(exp_status.open_cnt), 16'(bin_status_i.open_cnt));
            end
        end
    end

    task automatic check_reset_state();
        if (done_load_i !== 1'b0 || load_busy_i !== 1'b0 || base_lvl_valid_i !== 1'b0
            || status_valid_i !== 1'b0)
            fault("control outputs not low after reset");
        if (wr_carray_i !== '0 || wr_var_states_i !== '0 || wr_lvl_states_i !== '0)
            fault("write strobes not zero after reset");
    endtask

    task automatic end_test(input string name, input bit is_load);
        if (is_load)
        begin
            if (done_cnt != 1)
                fault($sformatf("%0d done pulses instead of one", done_cnt));
            if (status_cnt != 1)
                fault($sformatf("%0d status pulses instead of one", status_cnt));
            if (c_pos != 8 || v_pos != 8 || l_pos != 8)
                fault("a strobe stream did not cover all eight bits once");
        end
        if (errors == 0)
        begin
            $display("test %s: pass", name);
            num_pass_o++;
        end
        else
        begin
            $display("test %s: FAIL with %0d errors", name, errors);
            num_fail_o++;
        end
        // counts for the next test start here
        errors     = 0;
        done_cnt   = 0;
        status_cnt = 0;
        c_pos      = 0;
        v_pos      = 0;
        l_pos      = 0;
    endtask

endmodule

`default_nettype wire

// ==== sat_bin_top.sv ====
`timescale 1ns/1ps
`default_nettype none
// bin-swap path top: stores, loader, clause slot row and evaluator

module sat_bin_top
    import sat_bin_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst,
    input  wire host_wr_t             host_wr_i,
    input  wire                       start_load_i,
    input  wire [WIDTH_BIN_ID-1:0]    request_bin_i,
    input  wire [WIDTH_LVL-1:0]       cur_lvl_i,
    output logic                      load_busy_o,
    output logic                      done_load_o,
    output logic [WIDTH_LVL-1:0]      base_lvl_o,
    output logic                      base_lvl_valid_o,
    output lvl_state_t                lvl_state_o,
    output logic [NUM_LVLS_A_BIN-1:0] wr_lvl_states_o,
    output logic                      status_valid_o,
    output bin_status_t               bin_status_o
);

    logic [ADDR_WIDTH_BIN_MEM-1:0] clause_addr;
    logic [ADDR_WIDTH_BIN_MEM-1:0] var_addr;
    logic [WIDTH_VAR_ID-1:0]       vstate_addr;
    logic [WIDTH_LVL-1:0]          lstate_addr;
    logic [WIDTH_CLAUSE-1:0]       clause_data;
    logic [WIDTH_VAR_ID-1:0]       var_id;
    var_state_t                    vstate;
    lvl_state_t                    lstate;

    logic [WIDTH_CLAUSE-1:0]      clause;
    logic [NUM_CLAUSES_A_BIN-1:0] wr_carray;
    var_state_t                   var_state;
    logic [NUM_VARS_A_BIN-1:0]    wr_var_states;
    clause_res_t                  slot_res [NUM_CLAUSES_A_BIN];

    bin_store u_bin_store (
        .clk           (clk),
        .host_wr_i     (host_wr_i),
        .clause_addr_i (clause_addr),
        .var_addr_i    (var_addr),
        .vstate_addr_i (vstate_addr),
        .lstate_addr_i (lstate_addr),
        .clause_data_o (clause_data),
        .var_id_o      (var_id),
        .vstate_o      (vstate),
        .lstate_o      (lstate)
    );

    load_bin u_load_bin (
        .clk              (clk),
        .rst              (rst),
        .start_load_i     (start_load_i),
        .request_bin_i    (request_bin_i),
        .cur_lvl_i        (cur_lvl_i),
        .clause_data_i    (clause_data),
        .var_id_i         (var_id),
        .vstate_i         (vstate),
        .lstate_i         (lstate),
        .clause_addr_o    (clause_addr),
        .var_addr_o       (var_addr),
        .vstate_addr_o    (vstate_addr),
        .lstate_addr_o    (lstate_addr),
        .clause_o         (clause),
        .wr_carray_o      (wr_carray),
        .var_state_o      (var_state),
        .wr_var_states_o  (wr_var_states),
        .lvl_state_o      (lvl_state_o),
        .wr_lvl_states_o  (wr_lvl_states_o),
        .base_lvl_o       (base_lvl_o),
        .base_lvl_valid_o (base_lvl_valid_o),
        .load_busy_o      (load_busy_o),
        .done_load_o      (done_load_o)
    );

    // slot i takes the clause on strobe bit i, all slots take every var state
    for (genvar i = 0; i < NUM_CLAUSES_A_BIN; i++)
    begin : g_slot
        clause_slot u_clause_slot (
            .clk             (clk),
            .rst             (rst),
            .wr_clause_i     (wr_carray[i]),
            .clause_i        (clause),
            .wr_var_states_i (wr_var_states),
            .var_state_i     (var_state),
            .res_o           (slot_res[i])
        );
    end

    bin_eval u_bin_eval (
        .clk            (clk),
        .rst            (rst),
        .done_load_i    (done_load_o),
        .res_i          (slot_res),
        .status_valid_o (status_valid_o),
        .bin_status_o   (bin_status_o)
    );

endmodule

`default_nettype wire

// ==== bin_eval.sv ====
`timescale 1ns/1ps
`default_nettype none
// reduces slot results into a bin status at the end of a load

module bin_eval
    import sat_bin_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire              done_load_i,
    input  wire clause_res_t res_i [NUM_CLAUSES_A_BIN],
    output logic             status_valid_o,
    output bin_status_t      bin_status_o
);

    bin_status_t status_next;

    always_comb
    begin
        status_next.bin_sat      = 1'b1;
        status_next.bin_conflict = 1'b0;
        status_next.unit_cnt     = '0;
        status_next.open_cnt     = '0;
        for (int i = 0; i < NUM_CLAUSES_A_BIN; i++)
        begin
            // empty clauses do not block bin_sat
            if (res_i[i].active && !res_i[i].sat)
                status_next.bin_sat = 1'b0;
            if (res_i[i].conflict)
                status_next.bin_conflict = 1'b1;
            if (res_i[i].unit)
                status_next.unit_cnt = status_next.unit_cnt + 1'b1;
            if (!res_i[i].sat && !res_i[i].conflict)
                status_next.open_cnt = status_next.open_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
            status_valid_o <= 1'b0;
        else
            status_valid_o <= done_load_i;
    end

    always_ff @(posedge clk)
    begin
        if (done_load_i)
            bin_status_o <= status_next;
    end

endmodule

`default_nettype wire

// ==== clause_slot.sv ====
`timescale 1ns/1ps
`default_nettype none
// one clause row with its variable values
// classifies the clause as satisfied, conflict or unit

module clause_slot
    import sat_bin_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      wr_clause_i,
    input  wire [WIDTH_CLAUSE-1:0]   clause_i,
    input  wire [NUM_VARS_A_BIN-1:0] wr_var_states_i,
    input  wire var_state_t          var_state_i,
    output clause_res_t              res_o
);

    logic [WIDTH_CLAUSE-1:0]   lits;
    logic [NUM_VARS_A_BIN-1:0] asg;
    logic [NUM_VARS_A_BIN-1:0] val;
    logic [NUM_VARS_A_BIN-1:0] present;
    logic [NUM_VARS_A_BIN-1:0] lit_true;
    logic [NUM_VARS_A_BIN-1:0] lit_open;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            lits <= '0;
            asg  <= '0;
        end
        else
        begin
            if (wr_clause_i)
                lits <= clause_i;
            for (int k = 0; k < NUM_VARS_A_BIN; k++)
            begin
                if (wr_var_states_i[k])
                    asg[k] <= var_state_i.assigned;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        for (int k = 0; k < NUM_VARS_A_BIN; k++)
        begin
            if (wr_var_states_i[k])
                val[k] <= var_state_i.value;
        end
    end

    // code 2'b11 is unused and reads as negative
    always_comb
    begin
        for (int k = 0; k < NUM_VARS_A_BIN; k++)
        begin
            present[k]  = (lits[2*k +: 2] != LIT_ABSENT);
            lit_true[k] = present[k] && asg[k] && (val[k] == (lits[2*k +: 2] == LIT_POS));
            lit_open[k] = present[k] && !asg[k];
        end
    end

    assign res_o.active   = |present;
    assign res_o.sat      = |lit_true;
    assign res_o.conflict = (|present) && !(|lit_true) && !(|lit_open);
    assign res_o.unit     = !(|lit_true) && $onehot(lit_open);

endmodule

`default_nettype wire

// ==== load_bin.sv ====
`timescale 1ns/1ps
`default_nettype none
// bin loader: clause and variable-id sequencing, variable-state lookup,
// base-level search down the level list, one-hot write strobes

module load_bin
    import sat_bin_pkg::*;
(
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           start_load_i,
    input  wire [WIDTH_BIN_ID-1:0]        request_bin_i,
    input  wire [WIDTH_LVL-1:0]           cur_lvl_i,
    input  wire [WIDTH_CLAUSE-1:0]        clause_data_i,
    input  wire [WIDTH_VAR_ID-1:0]        var_id_i,
    input  wire var_state_t               vstate_i,
    input  wire lvl_state_t               lstate_i,
    output logic [ADDR_WIDTH_BIN_MEM-1:0] clause_addr_o,
    output logic [ADDR_WIDTH_BIN_MEM-1:0] var_addr_o,
    output logic [WIDTH_VAR_ID-1:0]       vstate_addr_o,
    output logic [WIDTH_LVL-1:0]          lstate_addr_o,
    output logic [WIDTH_CLAUSE-1:0]       clause_o,
    output logic [NUM_CLAUSES_A_BIN-1:0]  wr_carray_o,
    output var_state_t                    var_state_o,
    output logic [NUM_VARS_A_BIN-1:0]     wr_var_states_o,
    output lvl_state_t                    lvl_state_o,
    output logic [NUM_LVLS_A_BIN-1:0]     wr_lvl_states_o,
    output logic [WIDTH_LVL-1:0]          base_lvl_o,
    output logic                          base_lvl_valid_o,
    output logic                          load_busy_o,
    output logic                          done_load_o
);

    logic                          start_ok;
    logic [ADDR_WIDTH_BIN_MEM-1:0] bin_base;
    logic [WIDTH_BIN_ID-1:0]       req_bin;
    logic [WIDTH_LVL-1:0]          start_lvl;

    // clause and variable-id stream
    logic                 rd_act;
    logic [IDX_WIDTH-1:0] rd_idx;
    logic                 rd_first;
    logic                 cdata_first;
    logic                 vdata_first;

    // level search and level stream
    logic                 searching;
    logic                 chk;
    logic [WIDTH_LVL-1:0] srch_lvl;
    logic [WIDTH_LVL-1:0] chk_lvl;
    logic                 hit;
    logic                 stop;
    logic [WIDTH_LVL-1:0] base_next;
    logic                 lrd_act;
    logic [IDX_WIDTH-1:0] lrd_idx;
    logic                 lrd_first;
    logic                 ldata_first;

    logic v_fin;
    logic l_fin;
    logic v_last;
    logic l_last;
    logic all_done;

    assign start_ok = start_load_i && !load_busy_o;

    always_ff @(posedge clk)
    begin
        if (start_ok)
        begin
            bin_base  <= ADDR_WIDTH_BIN_MEM'(request_bin_i * NUM_CLAUSES_A_BIN);
            req_bin   <= request_bin_i;
            start_lvl <= cur_lvl_i;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            rd_act <= 1'b0;
            rd_idx <= '0;
        end
        else if (start_ok)
        begin
            rd_act <= 1'b1;
            rd_idx <= '0;
        end
        else if (rd_act)
        begin
            rd_idx <= rd_idx + 1'b1;
            if (rd_idx == IDX_WIDTH'(NUM_CLAUSES_A_BIN - 1))
                rd_act <= 1'b0;
        end
    end

    assign clause_addr_o = bin_base + ADDR_WIDTH_BIN_MEM'(rd_idx);
    assign var_addr_o    = bin_base + ADDR_WIDTH_BIN_MEM'(rd_idx);
    // returned ids go straight back out as state addresses
    assign vstate_addr_o = var_id_i;
    assign rd_first      = rd_act && (rd_idx == '0);

    // strobes start one cycle after the first data word, then shift
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            cdata_first     <= 1'b0;
            vdata_first     <= 1'b0;
            ldata_first     <= 1'b0;
            wr_carray_o     <= '0;
            wr_var_states_o <= '0;
            wr_lvl_states_o <= '0;
        end
        else
        begin
            cdata_first     <= rd_first;
            vdata_first     <= cdata_first;
            ldata_first     <= lrd_first;
            wr_carray_o     <= {wr_carray_o[NUM_CLAUSES_A_BIN-2:0], cdata_first};
            wr_var_states_o <= {wr_var_states_o[NUM_VARS_A_BIN-2:0], vdata_first};
            wr_lvl_states_o <= {wr_lvl_states_o[NUM_LVLS_A_BIN-2:0], ldata_first};
        end
    end

    always_ff @(posedge clk)
    begin
        clause_o    <= clause_data_i;
        var_state_o <= vstate_i;
        lvl_state_o <= lstate_i;
    end

    // search reads one level per cycle, the compare trails by one
    assign hit  = (lstate_i.dcd_bin == req_bin);
    assign stop = chk && (!hit || (chk_lvl == '0));

    always_comb
    begin
        if (hit)
            base_next = chk_lvl;
        else if (chk_lvl == start_lvl)
            base_next = start_lvl;
        else
            base_next = chk_lvl + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            searching        <= 1'b0;
            chk              <= 1'b0;
            lrd_act          <= 1'b0;
            lrd_idx          <= '0;
            base_lvl_valid_o <= 1'b0;
        end
        else if (start_ok)
        begin
            searching        <= 1'b1;
            chk              <= 1'b0;
            base_lvl_valid_o <= 1'b0;
        end
        else if (stop)
        begin
            searching        <= 1'b0;
            chk              <= 1'b0;
            lrd_act          <= 1'b1;
            lrd_idx          <= '0;
            base_lvl_valid_o <= 1'b1;
        end
        else if (searching)
            chk <= 1'b1;
        else if (lrd_act)
        begin
            lrd_idx <= lrd_idx + 1'b1;
            if (lrd_idx == IDX_WIDTH'(NUM_LVLS_A_BIN - 1))
                lrd_act <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (start_ok)
            srch_lvl <= cur_lvl_i;
        else if (searching)
            srch_lvl <= srch_lvl - 1'b1;
        chk_lvl <= srch_lvl;
        if (stop)
            base_lvl_o <= base_next;
    end

    assign lstate_addr_o = searching ? srch_lvl : base_lvl_o + WIDTH_LVL'(lrd_idx);
    assign lrd_first     = lrd_act && (lrd_idx == '0);

    // clause strobes always end a cycle before the variable states
    assign v_last   = wr_var_states_o[NUM_VARS_A_BIN-1];
    assign l_last   = wr_lvl_states_o[NUM_LVLS_A_BIN-1];
    assign all_done = load_busy_o && (v_fin || v_last) && (l_fin || l_last);

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            load_busy_o <= 1'b0;
            done_load_o <= 1'b0;
            v_fin       <= 1'b0;
            l_fin       <= 1'b0;
        end
        else
        begin
            done_load_o <= all_done;
            if (start_ok)
                load_busy_o <= 1'b1;
            else if (all_done)
                load_busy_o <= 1'b0;
            v_fin <= !(start_ok || all_done) && (v_fin || v_last);
            l_fin <= !(start_ok || all_done) && (l_fin || l_last);
        end
    end

endmodule

`default_nettype wire

// ==== bin_store.sv ====
`timescale 1ns/1ps
`default_nettype none
// clause, variable-id, variable-state and level-state memories
// host write port and one registered read port per memory

module bin_store
    import sat_bin_pkg::*;
(
    input  wire                          clk,
    input  wire host_wr_t                host_wr_i,
    input  wire [ADDR_WIDTH_BIN_MEM-1:0] clause_addr_i,
    input  wire [ADDR_WIDTH_BIN_MEM-1:0] var_addr_i,
    input  wire [WIDTH_VAR_ID-1:0]       vstate_addr_i,
    input  wire [WIDTH_LVL-1:0]          lstate_addr_i,
    output logic [WIDTH_CLAUSE-1:0]      clause_data_o,
    output logic [WIDTH_VAR_ID-1:0]      var_id_o,
    output var_state_t                   vstate_o,
    output lvl_state_t                   lstate_o
);

    logic [WIDTH_CLAUSE-1:0] clause_mem [BIN_MEM_DEPTH];
    logic [WIDTH_VAR_ID-1:0] var_mem    [BIN_MEM_DEPTH];
    var_state_t              vstate_mem [VSTATE_DEPTH];
    lvl_state_t              lstate_mem [LVL_DEPTH];

    // narrower memories keep the low data bits
    always_ff @(posedge clk)
    begin
        if (host_wr_i.strobe)
        begin
            case (host_wr_i.sel)
                MEM_CLAUSE:
                    clause_mem[host_wr_i.addr] <= host_wr_i.data[WIDTH_CLAUSE-1:0];
                MEM_VAR:
                    var_mem[host_wr_i.addr] <= host_wr_i.data[WIDTH_VAR_ID-1:0];
                MEM_VSTATE:
                    vstate_mem[host_wr_i.addr] <= host_wr_i.data[$bits(var_state_t)-1:0];
                MEM_LSTATE:
                    lstate_mem[host_wr_i.addr] <= host_wr_i.data[$bits(lvl_state_t)-1:0];
                default:
                    ;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        clause_data_o <= clause_mem[clause_addr_i];
        var_id_o      <= var_mem[var_addr_i];
        vstate_o      <= vstate_mem[vstate_addr_i];
        lstate_o      <= lstate_mem[lstate_addr_i];
    end

endmodule

`default_nettype wire

// ==== sat_bin_pkg.sv ====
`default_nettype none
// bin sizes, widths, literal and host select encodings
// packed structs shared by the stores, loader, slots and evaluator

package sat_bin_pkg;

    // bin geometry
    localparam int NUM_CLAUSES_A_BIN = 8;
    localparam int NUM_VARS_A_BIN    = 8;
    localparam int NUM_LVLS_A_BIN    = 8;
    localparam int IDX_WIDTH         = 3;

    localparam int WIDTH_BIN_ID       = 10;
    localparam int WIDTH_LVL          = 9;
    localparam int WIDTH_VAR_ID       = 9;
    localparam int ADDR_WIDTH_BIN_MEM = 9;
    localparam int WIDTH_CLAUSE       = 2 * NUM_VARS_A_BIN;
    localparam int WIDTH_CNT          = 4;

    localparam int BIN_MEM_DEPTH   = 2 ** ADDR_WIDTH_BIN_MEM;
    localparam int VSTATE_DEPTH    = 2 ** WIDTH_VAR_ID;
    localparam int LVL_DEPTH       = 2 ** WIDTH_LVL;
    localparam int HOST_ADDR_WIDTH = 9;
    localparam int HOST_DATA_WIDTH = 16;

    // literal code per bin variable position
    localparam logic [1:0] LIT_ABSENT = 2'b00;
    localparam logic [1:0] LIT_POS    = 2'b01;
    localparam logic [1:0] LIT_NEG    = 2'b10;

    // host memory select
    localparam logic [1:0] MEM_CLAUSE = 2'd0;
    localparam logic [1:0] MEM_VAR    = 2'd1;
    localparam logic [1:0] MEM_VSTATE = 2'd2;
    localparam logic [1:0] MEM_LSTATE = 2'd3;

    typedef struct packed {
        logic                 assigned;
        logic                 value;
        logic [WIDTH_LVL-1:0] level;
    } var_state_t;

    typedef struct packed {
        logic [WIDTH_BIN_ID-1:0] dcd_bin;
        logic                    has_bkt;
    } lvl_state_t;

    typedef struct packed {
        logic                       strobe;
        logic [1:0]                 sel;
        logic [HOST_ADDR_WIDTH-1:0] addr;
        logic [HOST_DATA_WIDTH-1:0] data;
    } host_wr_t;

    // active marks a clause with at least one literal present
    typedef struct packed {
        logic active;
        logic sat;
        logic conflict;
        logic unit;
    } clause_res_t;

    typedef struct packed {
        logic                 bin_sat;
        logic                 bin_conflict;
        logic [WIDTH_CNT-1:0] unit_cnt;
        logic [WIDTH_CNT-1:0] open_cnt;
    } bin_status_t;

endpackage

`default_nettype wire
